// ==== bench/tb_video_top.sv ====
`timescale 1ns/1ps

module tb_video_top;

    import video_pkg::*;

    localparam int CROP_OFFSET     = 4;
    localparam int CROP_WIDTH      = 8;
    localparam int PAN_MAX         = 3;
    localparam int HEARTBEAT_TICKS = 20;
    localparam int LINE_PIXELS     = 24;          // window fits at every pan
    localparam int DRAIN_TIMEOUT   = 40;          // edges allowed to empty a line

    logic   core_clk = 1'b0;
    logic   rst_n_i;
    logic   cmos_vsync_i;
    logic   cmos_href_i;
    byte_t  cmos_data_i;
    logic   key_invert_i;
    logic   key_pan_i;
    logic   vs_o;
    logic   de_o;
    chan8_t r_o;
    chan8_t g_o;
    chan8_t b_o;
    logic   heartbeat_o;

    bit          checks_on   = 1'b0;              // set once reset has reached the DUT
    int unsigned edge_cnt    = 0;                 // rising edges since time 0
    int unsigned rel_cnt     = 0;                 // rising edges since reset release
    logic [3:0]  vs_hist     = '0;                // cmos vsync as sampled with newest in bit 0
    logic [31:0] lcg_state   = 32'ha68f;
    int unsigned pan_presses = 0;
    int unsigned inv_presses = 0;
    logic [23:0] exp_rgb[$];                      // model output pixels, in order
    int unsigned exp_edge[$];                     // edge each one must appear after

    video_top #(
        .CROP_OFFSET     (CROP_OFFSET),
        .CROP_WIDTH      (CROP_WIDTH),
        .PAN_MAX         (PAN_MAX),
        .HEARTBEAT_TICKS (HEARTBEAT_TICKS)
    ) uut (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n_i),
        .cmos_vsync_i (cmos_vsync_i),
        .cmos_href_i  (cmos_href_i),
        .cmos_data_i  (cmos_data_i),
        .key_invert_i (key_invert_i),
        .key_pan_i    (key_pan_i),
        .vs_o         (vs_o),
        .de_o         (de_o),
        .r_o          (r_o),
        .g_o          (g_o),
        .b_o          (b_o),
        .heartbeat_o  (heartbeat_o)
    );

    initial
    begin
        forever
        begin
            #2 core_clk = 1'b1;                   // 4 ns period
            #2 core_clk = 1'b0;
        end
    end

    always @(posedge core_clk)
    begin
        edge_cnt <= edge_cnt + 1;
        vs_hist  <= {vs_hist[2:0], cmos_vsync_i};
        rel_cnt  <= rst_n_i ? rel_cnt + 1 : 0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_mismatch(input string sig, input int unsigned got,
                                  input int unsigned want);
        $display("[FAIL] t=%0t %s = 0x%0h, expected 0x%0h", $time, sig, got, want);
        end_with_failure();
    endtask

    task automatic fail_with_reason(input string what);
        $display("t=%0t %s", $time, what);
        end_with_failure();
    endtask

    function automatic byte_t rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];                  // middle bits are less regular
    endfunction

    // rgb565 from the byte pair widened by zero fill
    function automatic logic [23:0] expand_pixel(input byte_t hi, input byte_t lo,
                                                 input bit inv);
        logic [15:0] p;
        p = inv ? ~{hi, lo} : {hi, lo};
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    function automatic logic hb_level(input int unsigned edges);
        return ((edges / HEARTBEAT_TICKS) % 2) == 0;   // high until first toggle
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge core_clk);
    endtask

    task automatic press_key(input bit pan_key);
        if (pan_key)
            key_pan_i = 1'b1;
        else
            key_invert_i = 1'b1;
        idle_cycles(3);
        key_pan_i    = 1'b0;
        key_invert_i = 1'b0;
        idle_cycles(8);                           // sync, edge and count settle
        if (pan_key)
            pan_presses++;
        else
            inv_presses++;
    endtask

    task automatic send_vsync();
        cmos_vsync_i = 1'b1;
        idle_cycles(4);
        cmos_vsync_i = 1'b0;
        idle_cycles(6);
    endtask

    // wait for every expected pixel of the line
    task automatic drain_pixels();
        int waited;
        waited = 0;
        while (exp_rgb.size() != 0)
        begin
            if (waited >= DRAIN_TIMEOUT)
                fail_with_reason("timeout waiting for the pixels of a line on de_o");
            else
            begin
                @(posedge core_clk);
                waited++;
            end
        end
        @(negedge core_clk);
        idle_cycles(2);
    endtask

    task automatic send_line();
        byte_t hi;
        byte_t lo;
        int    col;
        int    start;
        start = CROP_OFFSET + (pan_presses % (PAN_MAX + 1));   // wraps past PAN_MAX
        for (col = 0; col < LINE_PIXELS; col++)
        begin
            hi           = rand_byte();
            lo           = rand_byte();
            cmos_href_i  = 1'b1;
            cmos_data_i  = hi;                    // high byte first
            @(negedge core_clk);
            cmos_data_i  = lo;
            if (col >= start && col < start + CROP_WIDTH)
            begin
                exp_rgb.push_back(expand_pixel(hi, lo, inv_presses % 2 == 1));
                exp_edge.push_back(edge_cnt + 1 + PIPE_LATENCY);   // lo taken next edge
            end
            @(negedge core_clk);
        end
        cmos_href_i = 1'b0;
        cmos_data_i = '0;
        drain_pixels();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks

    always @(negedge core_clk)
    begin : pixel_check
        logic [23:0] want_rgb;
        int unsigned want_edge;
        if (checks_on && de_o)
        begin
            if (exp_rgb.size() == 0)
                fail_with_reason("de_o high for a pixel outside the crop window");
            else
            begin
                want_rgb  = exp_rgb.pop_front();
                want_edge = exp_edge.pop_front();
                assert (edge_cnt == want_edge)
                    else value_mismatch("de_o edge", edge_cnt, want_edge);
                assert (r_o == want_rgb[23:16])
                    else value_mismatch("r_o", r_o, want_rgb[23:16]);
                assert (g_o == want_rgb[15:8])
                    else value_mismatch("g_o", g_o, want_rgb[15:8]);
                assert (b_o == want_rgb[7:0])
                    else value_mismatch("b_o", b_o, want_rgb[7:0]);
            end
        end
    end

    reset_idle: assert property (@(posedge core_clk) disable iff (!checks_on)
        !rst_n_i |-> (!de_o && !vs_o && heartbeat_o))
        else fail_with_reason("outputs not idle while reset is asserted");

    blank_rgb: assert property (@(posedge core_clk) disable iff (!checks_on)
        !de_o |-> (r_o == '0 && g_o == '0 && b_o == '0))
        else fail_with_reason("colour outputs not cleared while de_o is low");

    // vs_o is the level sampled 3 edges before its own update edge
    vsync_delay: assert property (@(posedge core_clk) disable iff (!checks_on)
        vs_o == vs_hist[3])
        else value_mismatch("vs_o", $sampled(vs_o), $sampled(vs_hist[3]));

    heartbeat_period: assert property (@(posedge core_clk) disable iff (!checks_on)
        heartbeat_o == hb_level(rel_cnt))
        else value_mismatch("heartbeat_o", $sampled(heartbeat_o),
                            hb_level($sampled(rel_cnt)));

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial
    begin : stimulus
        int k;
        rst_n_i      = 1'b0;
        cmos_vsync_i = 1'b0;
        cmos_href_i  = 1'b0;
        cmos_data_i  = '0;
        key_invert_i = 1'b0;
        key_pan_i    = 1'b0;
        @(negedge core_clk);
        checks_on = 1'b1;
        idle_cycles(7);                           // 8 rising edges in reset
        rst_n_i = 1'b1;
        idle_cycles(10);
        send_vsync();
        send_line();                              // pan 0 and normal colours
        send_line();
        for (k = 0; k < 5; k++)
        begin
            press_key(1'b1);                      // pan steps 1, 2, 3, 0, 1
            send_line();
        end
        send_vsync();
        press_key(1'b0);                          // inverted
        send_line();
        send_line();
        press_key(1'b0);                          // back to normal
        send_line();
        press_key(1'b1);
        press_key(1'b0);
        send_line();
        send_vsync();
        idle_cycles(10);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
src/video_pkg.sv
src/ctrl_pkg.sv
src/pix_if.sv
src/cam_sync_pack.sv
src/line_crop.sv
src/color_out.sv
src/key_step.sv
src/heartbeat.sv
src/video_top.sv
bench/tb_video_top.sv

// ==== src/cam_sync_pack.sv ====
`timescale 1ns/1ps

module cam_sync_pack
(
    input  logic             core_clk,
    input  logic             rst_n_i,
    input  logic             cmos_vsync_i,
    input  logic             cmos_href_i,
    input  video_pkg::byte_t cmos_data_i,
    pix_if.producer          pix_o
);

    import video_pkg::*;

    byte_t data_q;                                // registered cmos byte
    logic  href_q;                                // registered href
    logic  vsync_q;                               // registered vsync
    byte_t hi_byte_q;                             // first byte of the pair
    logic  phase_q;                               // 1 = waiting for low byte

    ////////////////////////////////////////////////////////////////////////////
    // input register

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            href_q  <= 1'b0;
            vsync_q <= 1'b0;
        end
        else
        begin
            href_q  <= cmos_href_i;
            vsync_q <= cmos_vsync_i;
        end
    end

    always_ff @(posedge core_clk)
    begin
        data_q <= cmos_data_i;                    // byte only, no reset
    end

    ////////////////////////////////////////////////////////////////////////////
    // pack register, high byte first

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            phase_q         <= 1'b0;
            pix_o.pix_valid <= 1'b0;
            pix_o.vsync     <= 1'b0;
            pix_o.href      <= 1'b0;
        end
        else
        begin
            pix_o.vsync <= vsync_q;               // levels follow the pack delay
            pix_o.href  <= href_q;
            if (href_q)
            begin
                phase_q         <= ~phase_q;      // alternate hi / lo
                pix_o.pix_valid <= phase_q;       // strobe on the low byte
            end
            else
            begin
                phase_q         <= 1'b0;          // pair phase restarts per line
                pix_o.pix_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (href_q && !phase_q)
            hi_byte_q <= data_q;                  // hold until partner arrives
        if (href_q && phase_q)
            pix_o.pix_data <= {hi_byte_q, data_q};
    end

    // one pixel per two bytes, so the strobe can never repeat back to back
    assert property (@(posedge core_clk) disable iff (!rst_n_i)
        pix_o.pix_valid |=> !pix_o.pix_valid);

endmodule

// ==== src/color_out.sv ====
`timescale 1ns/1ps

module color_out
(
    input  logic               core_clk,
    input  logic               rst_n_i,
    input  logic               invert_i,
    pix_if.consumer            pix_i,
    output logic               vs_o,
    output logic               de_o,
    output video_pkg::chan8_t  r_o,
    output video_pkg::chan8_t  g_o,
    output video_pkg::chan8_t  b_o
);

    import video_pkg::*;

    rgb565_t pix;                                 // pixel after optional invert

    assign pix = invert_i ? ~pix_i.pix_data : pix_i.pix_data;

    // widen by zero fill in the low bits, blank outside valid pixels
    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            vs_o <= 1'b0;
            de_o <= 1'b0;
            r_o  <= '0;
            g_o  <= '0;
            b_o  <= '0;
        end
        else
        begin
            vs_o <= pix_i.vsync;
            de_o <= pix_i.pix_valid;
            if (pix_i.pix_valid)
            begin
                r_o <= {pix[B_BITS+G_BITS +: R_BITS], {(CHAN_BITS-R_BITS){1'b0}}};
                g_o <= {pix[B_BITS +: G_BITS], {(CHAN_BITS-G_BITS){1'b0}}};
                b_o <= {pix[0 +: B_BITS], {(CHAN_BITS-B_BITS){1'b0}}};
            end
            else
            begin
                r_o <= '0;                        // black between pixels
                g_o <= '0;
                b_o <= '0;
            end
        end
    end

    // pixels reaching the output stage always lie inside an active line
    assert property (@(posedge core_clk) disable iff (!rst_n_i)
        pix_i.pix_valid |-> pix_i.href);

endmodule

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

    // key stepped pan setting
    localparam int PAN_BITS = 7;                  // holds 0..64
    typedef logic [PAN_BITS-1:0] pan_t;           // crop start offset in columns

    // largest pan step, wraps to 0 on the next press
    localparam int PAN_MAX_DEFAULT = 64;

    // heartbeat led
    // about one second at the core clock rate
    localparam int HEARTBEAT_TICKS_DEFAULT = 33_000_000;

endpackage

// ==== src/heartbeat.sv ====
`timescale 1ns/1ps

module heartbeat
#(
    parameter int HEARTBEAT_TICKS = ctrl_pkg::HEARTBEAT_TICKS_DEFAULT
)
(
    input  logic core_clk,
    input  logic rst_n_i,
    output logic heartbeat_o
);

    localparam int CNT_BITS = (HEARTBEAT_TICKS > 1) ? $clog2(HEARTBEAT_TICKS) : 1;

    logic [CNT_BITS-1:0] tick_q;                  // cycles since last toggle
    logic                wrap;

    assign wrap = (tick_q == CNT_BITS'(HEARTBEAT_TICKS - 1));

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            tick_q      <= '0;
            heartbeat_o <= 1'b1;                  // led on while in reset
        end
        else if (wrap)
        begin
            tick_q      <= '0;
            heartbeat_o <= ~heartbeat_o;          // blink
        end
        else
        begin
            tick_q <= tick_q + 1'b1;
        end
    end

endmodule

// ==== src/key_step.sv ====
`timescale 1ns/1ps

module key_step
#(
    parameter int CNT_WIDTH = 1,
    parameter int CNT_MAX   = 1
)
(
    input  logic                 core_clk,
    input  logic                 rst_n_i,
    input  logic                 key_i,
    output logic [CNT_WIDTH-1:0] count_o
);

    logic [2:0] key_sync_q;                       // two sync flops and last level
    logic       rise_q;                           // registered press pulse

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            key_sync_q <= '0;
            rise_q     <= 1'b0;
            count_o    <= '0;
        end
        else
        begin
            key_sync_q <= {key_sync_q[1:0], key_i};
            rise_q     <= key_sync_q[1] & ~key_sync_q[2];   // low to high only
            if (rise_q)
            begin
                if (count_o == CNT_WIDTH'(CNT_MAX))
                    count_o <= '0;                // wrap after the top step
                else
                    count_o <= count_o + 1'b1;
            end
        end
    end

    // setting stays in range over any sequence of presses
    assert property (@(posedge core_clk) disable iff (!rst_n_i)
        count_o <= CNT_WIDTH'(CNT_MAX));

endmodule

// ==== src/line_crop.sv ====
`timescale 1ns/1ps

module line_crop
#(
    parameter video_pkg::col_t CROP_OFFSET = 12'd344,
    parameter video_pkg::col_t CROP_WIDTH  = 12'd320
)
(
    input  logic           core_clk,
    input  logic           rst_n_i,
    input  ctrl_pkg::pan_t pan_i,
    pix_if.consumer        pix_i,
    pix_if.producer        pix_o
);

    import video_pkg::*;
    import ctrl_pkg::*;

    col_t    col_q;                               // column of the next pixel
    pan_t    pan_q;                               // pan held for the whole line
    col_t    win_start;                           // first column kept
    col_t    win_end;                             // first column dropped again
    logic    in_window;
    logic    valid_q;
    rgb565_t data_q;
    logic    vsync_q;
    logic    href_q;                              // also the previous href

    assign win_start = CROP_OFFSET + col_t'(pan_q);
    assign win_end   = win_start + CROP_WIDTH;
    assign in_window = (col_q >= win_start) && (col_q < win_end);

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            col_q   <= '0;
            pan_q   <= '0;
            valid_q <= 1'b0;
            vsync_q <= 1'b0;
            href_q  <= 1'b0;
        end
        else
        begin
            vsync_q <= pix_i.vsync;               // one edge like the pixels
            href_q  <= pix_i.href;
            valid_q <= pix_i.pix_valid && in_window;
            if (!pix_i.href)
                col_q <= '0;                      // back to column 0 between lines
            else if (pix_i.pix_valid)
                col_q <= col_q + 1'b1;
            if (pix_i.href && !href_q)
                pan_q <= pan_i;                   // take pan at line start only
        end
    end

    always_ff @(posedge core_clk)
    begin
        data_q <= pix_i.pix_data;                 // payload, qualified by valid_q
    end

    assign pix_o.pix_valid = valid_q;
    assign pix_o.pix_data  = data_q;
    assign pix_o.vsync     = vsync_q;
    assign pix_o.href      = href_q;

    // the crop only drops pixels, it never makes one
    assert property (@(posedge core_clk) disable iff (!rst_n_i)
        pix_o.pix_valid |-> $past(pix_i.pix_valid));

endmodule

// ==== src/pix_if.sv ====
`timescale 1ns/1ps

interface pix_if;

    import video_pkg::*;

    logic    pix_valid;                           // one cycle strobe per pixel
    rgb565_t pix_data;                            // pixel, valid with strobe
    logic    vsync;                               // frame level
    logic    href;                                // line active level

    // stage that sends pixels
    modport producer
    (
        output pix_valid,
        output pix_data,
        output vsync,
        output href
    );

    // stage that takes pixels, no ready back
    modport consumer
    (
        input  pix_valid,
        input  pix_data,
        input  vsync,
        input  href
    );

endinterface

// ==== src/video_pkg.sv ====
package video_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // field widths of the camera pixel path

    localparam int BYTE_BITS = 8;                 // camera parallel bus
    localparam int R_BITS    = 5;                 // rgb565 red field
    localparam int G_BITS    = 6;                 // rgb565 green field
    localparam int B_BITS    = 5;                 // rgb565 blue field
    localparam int CHAN_BITS = 8;                 // output channel width
    localparam int COL_BITS  = 12;                // column counter width

    ////////////////////////////////////////////////////////////////////////////
    // types

    typedef logic [BYTE_BITS-1:0] byte_t;                  // one cmos byte
    typedef logic [R_BITS+G_BITS+B_BITS-1:0] rgb565_t;     // {r5, g6, b5}
    typedef logic [CHAN_BITS-1:0] chan8_t;                 // r, g or b out
    typedef logic [COL_BITS-1:0] col_t;                    // pixel column in a line

    ////////////////////////////////////////////////////////////////////////////
    // latency

    // edges from the edge that samples the second byte of a pixel
    // (or a vsync level) until that pixel sits on the output registers
    // made of pack 1, crop 1 and output 1 after the input register
    localparam int PIPE_LATENCY = 3;

endpackage

// ==== src/video_top.sv ====
`timescale 1ns/1ps

module video_top
#(
    parameter video_pkg::col_t CROP_OFFSET     = 12'd344,
    parameter video_pkg::col_t CROP_WIDTH      = 12'd320,
    parameter int              PAN_MAX         = ctrl_pkg::PAN_MAX_DEFAULT,
    parameter int              HEARTBEAT_TICKS = ctrl_pkg::HEARTBEAT_TICKS_DEFAULT
)
(
    input  logic              core_clk,
    input  logic              rst_n_i,
    // camera
    input  logic              cmos_vsync_i,
    input  logic              cmos_href_i,
    input  video_pkg::byte_t  cmos_data_i,
    // keys
    input  logic              key_invert_i,
    input  logic              key_pan_i,
    // video out
    output logic              vs_o,
    output logic              de_o,
    output video_pkg::chan8_t r_o,
    output video_pkg::chan8_t g_o,
    output video_pkg::chan8_t b_o,
    output logic              heartbeat_o
);

    import video_pkg::*;
    import ctrl_pkg::*;

    pan_t pan;                                    // crop start step
    logic invert;                                 // colour inversion on

    pix_if cam_pix ();                            // packed camera pixels
    pix_if crop_pix ();                           // pixels inside the window

    ////////////////////////////////////////////////////////////////////////////
    // pixel path

    cam_sync_pack u_cam_sync_pack
    (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n_i),
        .cmos_vsync_i (cmos_vsync_i),
        .cmos_href_i  (cmos_href_i),
        .cmos_data_i  (cmos_data_i),
        .pix_o        (cam_pix)
    );

    line_crop #(
        .CROP_OFFSET (CROP_OFFSET),
        .CROP_WIDTH  (CROP_WIDTH)
    ) u_line_crop (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .pan_i    (pan),
        .pix_i    (cam_pix),
        .pix_o    (crop_pix)
    );

    color_out u_color_out
    (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .invert_i (invert),
        .pix_i    (crop_pix),
        .vs_o     (vs_o),
        .de_o     (de_o),
        .r_o      (r_o),
        .g_o      (g_o),
        .b_o      (b_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // key controls and heartbeat

    key_step #(
        .CNT_WIDTH (1),
        .CNT_MAX   (1)
    ) key_invert (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .key_i    (key_invert_i),
        .count_o  (invert)                        // toggles per press
    );

    key_step #(
        .CNT_WIDTH ($bits(pan_t)),
        .CNT_MAX   (PAN_MAX)
    ) key_pan (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .key_i    (key_pan_i),
        .count_o  (pan)
    );

    heartbeat #(
        .HEARTBEAT_TICKS (HEARTBEAT_TICKS)
    ) u_heartbeat (
        .core_clk    (core_clk),
        .rst_n_i     (rst_n_i),
        .heartbeat_o (heartbeat_o)
    );

    // vsync crosses all three stages in step with the pixels
    // the extra 1 is the input register edge that samples it
    assert property (@(posedge core_clk) disable iff (!rst_n_i)
        $past(rst_n_i, PIPE_LATENCY + 1) |-> vs_o == $past(cmos_vsync_i, PIPE_LATENCY + 1));

endmodule
